// ==== Bender.yml ====
package:
  name: cnn_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cnn_ctrl_pkg.sv
      - rtl/cnn_ctrl_ifs.sv
      - rtl/cmd_fifo.sv
      - rtl/cmd_sequencer.sv
      - rtl/op_timer.sv
      - rtl/cnn_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/cnn_ctrl_checker.sv
      - test/tb_cnn_ctrl.sv

// ==== rtl/cmd_fifo.sv ====
`include "cnn_ctrl_defines.svh"

module cmd_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_wr_en,
    input  cnn_ctrl_pkg::cmd_word_t i_wr_data,
    output logic                  o_full,
    cmd_rd_if.fifo_mp             rd
);
    import cnn_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    cmd_word_t   mem [`FIFO_DEPTH]; // Register array
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_count_t      count;
    logic             do_wr;
    logic             do_rd;

    assign o_full      = (count == fifo_count_t'(`FIFO_DEPTH));
    assign rd.empty    = (count == '0);
    assign rd.wr_count = count;
    assign rd.data     = mem[rd_ptr]; // First word falls through

    assign do_wr = i_wr_en && !o_full;   // Write while full is dropped
    assign do_rd = rd.rd_en && !rd.empty;

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= i_wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // Both or neither leave occupancy unchanged
            endcase
        end
    end

    // Sequencer never stalls, so a pop on empty means a short command
    a_rd_empty: assert property (@(posedge clk) disable iff (rst) rd.rd_en |-> !rd.empty);
    a_wr_full:  assert property (@(posedge clk) disable iff (rst) i_wr_en |-> !o_full);

endmodule

// ==== rtl/cmd_sequencer.sv ====
`include "cnn_ctrl_defines.svh"

module cmd_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic [6:0]              i_cmd_size,
    cmd_rd_if.seq_mp                rd,
    engine_if.seq_mp                eng,
    output logic                    o_dma_p1_reads_en,
    output cnn_ctrl_pkg::op_type_e  o_op_type,
    output logic                    o_padding,
    output logic [3:0]              o_stride,
    output cnn_ctrl_pkg::dma_addr_t o_p2_start_addr,
    output cnn_ctrl_pkg::dma_addr_t o_p3_start_addr,
    output cnn_ctrl_pkg::mem_addr_t o_result_addr,
    output logic                    o_op_run,
    output logic                    o_irq
);
    import cnn_ctrl_pkg::*;

    localparam logic [2:0] LAST_WORD = 3'(`CMD_WORDS - 1);
    localparam count16_t   PARA_STEP = count16_t'(`PARA);

    seq_state_e state, state_nxt;
    logic [2:0] word_idx;  // Word of the command being popped

    // Decoded command fields
    count16_t  num_center, num_corner, num_side;
    count16_t  out_ch;
    side_t     in_side, out_side;
    count16_t  out_surf;
    mem_addr_t weight_addr, data_addr;

    // Output point tracking
    side_t     w_cnt, h_cnt;
    count16_t  surf_cnt, chan_cnt;
    side_t     side_last, nxt_w, nxt_h;
    dma_addr_t row_base;               // p2 at the start of the current row
    dma_addr_t step_col, step_row;
    logic      any_valid, w_end, surf_done, last_point, op_type_ok;
    logic      nxt_w_edge, nxt_h_edge;
    op_count_t mac_sel;
    fifo_count_t cmd_total;

    assign any_valid  = eng.conv_valid | eng.maxpool_valid | eng.avepool_valid;
    assign side_last  = out_side - 8'd1;
    assign w_end      = (w_cnt == side_last);
    assign surf_done  = (count16_t'(surf_cnt + 16'd1) == out_surf);
    assign last_point = any_valid && surf_done && (count16_t'(chan_cnt + PARA_STEP) >= out_ch);
    assign op_type_ok = o_op_type inside {OP_CONV1, OP_CONV3, OP_CONV3P, OP_MAXPOOL, OP_AVEPOOL};
    assign cmd_total  = fifo_count_t'(i_cmd_size) * fifo_count_t'(`CMD_WORDS);

    assign step_col = dma_addr_t'(o_stride) * dma_addr_t'(`PARA);     // Next column
    assign step_row = dma_addr_t'(o_stride) * dma_addr_t'(in_side) * dma_addr_t'(`PARA);

    // Position of the point that starts after this valid
    always_comb begin
        nxt_w = surf_done || w_end ? '0 : w_cnt + 8'd1;
        nxt_h = surf_done ? '0 : (w_end ? h_cnt + 8'd1 : h_cnt);
    end

    assign nxt_w_edge = (nxt_w == '0) || (nxt_w == side_last);
    assign nxt_h_edge = (nxt_h == '0) || (nxt_h == side_last);

    // Corner, edge or centre MAC count
    always_comb begin
        if (nxt_w_edge && nxt_h_edge)      mac_sel = op_count_t'(num_corner);
        else if (nxt_w_edge || nxt_h_edge) mac_sel = op_count_t'(num_side);
        else                               mac_sel = op_count_t'(num_center);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (i_op_en) state_nxt = S_COLLECT;
            S_COLLECT: if (word_idx == LAST_WORD) state_nxt = S_ISSUE;
            S_ISSUE: begin
                if (op_type_ok)    state_nxt = S_WAIT_OP;
                else if (rd.empty) state_nxt = S_FINISH; // Unknown type is skipped
                else               state_nxt = S_COLLECT;
            end
            S_WAIT_OP: if (last_point) state_nxt = rd.empty ? S_FINISH : S_COLLECT;
            S_FINISH:  state_nxt = S_FINISH; // Held until reset
            default:   state_nxt = S_IDLE;
        endcase
    end

    assign rd.rd_en = (state == S_COLLECT); // One pop per COLLECT cycle
    assign o_op_run = (state == S_WAIT_OP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= S_IDLE;
            word_idx          <= '0;
            w_cnt             <= '0;
            h_cnt             <= '0;
            surf_cnt          <= '0;
            chan_cnt          <= '0;
            eng.conv_ready    <= 1'b0;
            eng.maxpool_ready <= 1'b0;
            eng.avepool_ready <= 1'b0;
            eng.engine_reset  <= 1'b1;
            o_irq             <= 1'b0;
            o_dma_p1_reads_en <= 1'b0;
        end else begin
            state <= state_nxt;
            o_irq <= o_irq | (state_nxt == S_FINISH);
            if (i_op_en) o_dma_p1_reads_en <= 1'b1;        // Host starts filling the FIFO
            if (rd.wr_count == cmd_total) o_dma_p1_reads_en <= 1'b0; // All commands in
            case (state)
                S_COLLECT: begin
                    eng.engine_reset <= 1'b1;
                    word_idx <= (word_idx == LAST_WORD) ? 3'd0 : word_idx + 3'd1;
                end
                S_ISSUE: begin
                    eng.engine_reset  <= 1'b0;
                    w_cnt             <= '0;
                    h_cnt             <= '0;
                    surf_cnt          <= '0;
                    chan_cnt          <= '0;
                    eng.conv_ready    <= o_op_type inside {OP_CONV1, OP_CONV3, OP_CONV3P};
                    eng.maxpool_ready <= (o_op_type == OP_MAXPOOL);
                    eng.avepool_ready <= (o_op_type == OP_AVEPOOL);
                end
                S_WAIT_OP: begin
                    if (any_valid) begin
                        w_cnt    <= nxt_w;
                        h_cnt    <= nxt_h;
                        surf_cnt <= surf_done ? '0 : count16_t'(surf_cnt + 16'd1);
                        if (surf_done) chan_cnt <= count16_t'(chan_cnt + PARA_STEP);
                    end
                    if (last_point) begin  // Lane done, drop on the next cycle
                        eng.conv_ready    <= 1'b0;
                        eng.maxpool_ready <= 1'b0;
                        eng.avepool_ready <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    // Command fields, addresses and MAC count
    always_ff @(posedge clk) begin
        if (state == S_COLLECT) begin
            case (word_idx)
                3'd0: begin
                    o_op_type  <= op_type_e'(rd.data[2:0]);
                    o_padding  <= rd.data[4];           // Passed through only
                    o_stride   <= rd.data[11:8];
                    num_center <= rd.data[31:16];
                end
                3'd1: begin
                    num_corner <= rd.data[15:0];
                    num_side   <= rd.data[31:16];
                end
                3'd2: out_ch <= rd.data[31:16]; // Input channels in 15:0 belong to the engine
                3'd3: begin
                    in_side  <= rd.data[7:0];
                    out_side <= rd.data[15:8];
                    out_surf <= rd.data[31:16];
                end
                3'd4: weight_addr   <= rd.data;
                3'd5: data_addr     <= rd.data;
                3'd6: o_result_addr <= rd.data;
                default: ;
            endcase
        end
        if (state == S_ISSUE) begin
            o_p2_start_addr <= dma_addr_t'(data_addr);
            row_base        <= dma_addr_t'(data_addr);
            o_p3_start_addr <= dma_addr_t'(weight_addr);
            eng.op_num      <= op_count_t'(num_corner); // First point is a corner
        end
        if (state == S_WAIT_OP && any_valid) begin
            eng.op_num <= mac_sel;
            if (surf_done) begin  // Next channel group rereads the same surface
                o_p2_start_addr <= dma_addr_t'(data_addr);
                row_base        <= dma_addr_t'(data_addr);
            end else if (w_end) begin
                o_p2_start_addr <= row_base + step_row;
                row_base        <= row_base + step_row;
            end else begin
                o_p2_start_addr <= o_p2_start_addr + step_col;
            end
        end
    end

    // Exactly one lane ready while a command runs, none in any other state
    a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        (state == S_WAIT_OP) ? $onehot({eng.conv_ready, eng.maxpool_ready, eng.avepool_ready})
                             : !(eng.conv_ready | eng.maxpool_ready | eng.avepool_ready));
    a_known_type: assert property (@(posedge clk) disable iff (rst)
        state == S_ISSUE |-> op_type_ok);

endmodule

// ==== rtl/cnn_ctrl_defines.svh ====
`ifndef CNN_CTRL_DEFINES_SVH
`define CNN_CTRL_DEFINES_SVH

// Width of one command word from the host
`define CMD_WIDTH 32

// Words per compressed layer command
`define CMD_WORDS 7

// Output channels handled per pass, also the byte step of the data address
`define PARA 16

`define FIFO_DEPTH 128 // Command FIFO capacity in words

`endif

// ==== rtl/cnn_ctrl_ifs.sv ====
// Head-of-queue view of the command FIFO
interface cmd_rd_if;
    import cnn_ctrl_pkg::*;

    logic        rd_en;    // Pops the head word at the clock edge
    cmd_word_t   data;     // Always the head word
    logic        empty;
    fifo_count_t wr_count; // Words currently stored

    modport fifo_mp (input rd_en, output data, empty, wr_count);
    modport seq_mp  (output rd_en, input data, empty, wr_count);
endinterface

// Lane handshake between the sequencer and the engine
interface engine_if;
    import cnn_ctrl_pkg::*;

    logic      conv_ready;
    logic      maxpool_ready;
    logic      avepool_ready;
    logic      conv_valid;    // One-cycle pulse per finished point
    logic      maxpool_valid;
    logic      avepool_valid;
    op_count_t op_num;        // MAC count of the point in progress
    logic      engine_reset;

    modport seq_mp (
        output conv_ready, maxpool_ready, avepool_ready, op_num, engine_reset,
        input  conv_valid, maxpool_valid, avepool_valid
    );
    modport eng_mp (
        input  conv_ready, maxpool_ready, avepool_ready, op_num, engine_reset,
        output conv_valid, maxpool_valid, avepool_valid
    );
endinterface

// ==== rtl/cnn_ctrl_pkg.sv ====
`include "cnn_ctrl_defines.svh"

package cnn_ctrl_pkg;

    typedef logic [`CMD_WIDTH-1:0] cmd_word_t;   // Raw command word
    typedef logic [29:0]           dma_addr_t;   // DMA burst address
    typedef logic [31:0]           mem_addr_t;   // Write-back byte address
    typedef logic [19:0]           op_count_t;   // MACs per output point
    typedef logic [7:0]            side_t;       // Feature map side length
    typedef logic [15:0]           count16_t;    // Surface size or channel count
    typedef logic [9:0]            fifo_count_t; // FIFO occupancy

    // Layer type carried in bits 2:0 of word 1
    typedef enum logic [2:0] {
        OP_IDLE    = 3'd0,
        OP_CONV1   = 3'd1, // 1x1 conv with ReLU
        OP_CONV3   = 3'd2, // 3x3 conv with ReLU
        OP_CONV3P  = 3'd3, // Padded 3x3 followed by 1x1
        OP_MAXPOOL = 3'd4,
        OP_AVEPOOL = 3'd5
    } op_type_e;

    typedef enum logic [2:0] {
        S_IDLE, S_COLLECT, S_ISSUE, S_WAIT_OP, S_FINISH
    } seq_state_e;

endpackage

// ==== rtl/cnn_ctrl_top.sv ====
module cnn_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic                    i_cmd_wr_en,
    input  cnn_ctrl_pkg::cmd_word_t i_cmd_wr_data,
    input  logic [6:0]              i_cmd_size,      // Commands loaded by the host
    output logic                    o_cmd_full,
    output logic                    o_dma_p1_reads_en,
    output cnn_ctrl_pkg::op_type_e  o_op_type,
    output logic                    o_padding,
    output logic [3:0]              o_stride,
    output cnn_ctrl_pkg::op_count_t o_op_num,
    output cnn_ctrl_pkg::dma_addr_t o_p2_start_addr, // Data burst start
    output cnn_ctrl_pkg::dma_addr_t o_p3_start_addr, // Weight burst start
    output cnn_ctrl_pkg::mem_addr_t o_result_addr,
    output logic                    o_op_run,
    output logic                    o_engine_reset,
    output logic                    o_point_done,
    output logic                    o_irq
);

    cmd_rd_if rd_if ();
    engine_if eng_if ();

    cmd_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (i_cmd_wr_en),
        .i_wr_data (i_cmd_wr_data),
        .o_full    (o_cmd_full),
        .rd        (rd_if.fifo_mp)
    );

    cmd_sequencer seq_i (
        .clk               (clk),
        .rst               (rst),
        .i_op_en           (i_op_en),
        .i_cmd_size        (i_cmd_size),
        .rd                (rd_if.seq_mp),
        .eng               (eng_if.seq_mp),
        .o_dma_p1_reads_en (o_dma_p1_reads_en),
        .o_op_type         (o_op_type),
        .o_padding         (o_padding),
        .o_stride          (o_stride),
        .o_p2_start_addr   (o_p2_start_addr),
        .o_p3_start_addr   (o_p3_start_addr),
        .o_result_addr     (o_result_addr),
        .o_op_run          (o_op_run),
        .o_irq             (o_irq)
    );

    op_timer timer_i (
        .clk (clk),
        .rst (rst),
        .eng (eng_if.eng_mp)
    );

    assign o_op_num       = eng_if.op_num;
    assign o_engine_reset = eng_if.engine_reset;
    // Write-back DMA takes one result per pulse
    assign o_point_done   = eng_if.conv_valid | eng_if.maxpool_valid | eng_if.avepool_valid;

endmodule

// ==== rtl/op_timer.sv ====
module op_timer (
    input  logic     clk,
    input  logic     rst,
    engine_if.eng_mp eng
);
    import cnn_ctrl_pkg::*;

    logic      active;  // Some lane is running
    logic      loaded;  // Countdown for this point already started
    op_count_t remain;
    op_count_t cur;     // Cycles left including this one
    logic      fire;

    assign active = (eng.conv_ready | eng.maxpool_ready | eng.avepool_ready)
                    && !eng.engine_reset;

    // First cycle of a point takes op_num straight from the sequencer
    assign cur  = loaded ? remain : eng.op_num;
    assign fire = active && (cur == '0);

    // Pulse only the lane that is ready
    assign eng.conv_valid    = fire && eng.conv_ready;
    assign eng.maxpool_valid = fire && eng.maxpool_ready;
    assign eng.avepool_valid = fire && eng.avepool_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (!active || fire) begin
            loaded <= 1'b0; // Reload from op_num for the next point
        end else begin
            loaded <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (active && !fire) begin
            remain <= cur - 20'd1;
        end
    end

    // Lane stays selected and out of reset while a point counts down
    a_lane_held: assert property (@(posedge clk) disable iff (rst)
        loaded |-> $stable({eng.conv_ready, eng.maxpool_ready, eng.avepool_ready})
                   && !eng.engine_reset);

endmodule

// ==== test/cmd_input.txt ====
# name  word1..word7 in hex (word1 holds type, padding, stride, centre count)
# then the number of output points in decimal, surface times output channels over 16
conv1_s1   00040101 00030002 00200010 00090303 00001000 00020000 80000000 18
conv3_s2   00090212 00060004 00100008 00100409 00002400 00030000 80001000 16
maxpool_s2 00030204 00030003 00200020 00100408 00000000 00040000 80002000 32
avepool_s1 00010105 00010000 00300030 00040202 00000000 00050000 80003000 12
conv3p_s1  00030113 00020001 00100010 00190505 00003000 00060000 80004000 25

// ==== test/cnn_ctrl_checker.sv ====
`include "cnn_ctrl_defines.svh"

module cnn_ctrl_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  cnn_ctrl_pkg::op_type_e  i_op_type,
    input  logic                    i_padding,
    input  logic [3:0]              i_stride,
    input  cnn_ctrl_pkg::op_count_t i_op_num,
    input  cnn_ctrl_pkg::dma_addr_t i_p2_start_addr,
    input  cnn_ctrl_pkg::dma_addr_t i_p3_start_addr,
    input  cnn_ctrl_pkg::mem_addr_t i_result_addr,
    input  logic                    i_op_run,
    input  logic                    i_point_done,
    input  logic                    i_irq,
    input  logic                    i_dma_p1_reads_en,
    input  logic                    i_cmd_full,
    input  logic                    i_engine_reset,
    output logic                    o_done,
    output int                      o_errors
);
    import cnn_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 2000; // Cycles allowed for any single wait
    localparam int HOLD_CHECK = 20;   // Cycles irq is watched after it rises

    string names [$];
    logic [`CMD_WORDS*`CMD_WIDTH-1:0] cmds [$];
    int    points [$];
    int    test_errs; // Errors of the test in progress
    int    n_pass;
    int    n_run;

    task automatic add_test(input string name,
                            input logic [`CMD_WORDS*`CMD_WIDTH-1:0] words, input int pts);
        names.push_back(name);
        cmds.push_back(words);
        points.push_back(pts);
    endtask

    task automatic check_val(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected 0x%0h actual 0x%0h", test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic close_test(input string test, input int n_points);
        n_run++;
        if (test_errs == 0) n_pass++;
        o_errors += test_errs;
        $display("%s: %0d points, %0d errors", test, n_points, test_errs);
    endtask

    // All samples are taken on the falling edge, between DUT updates
    task automatic run_test(input int t);
        cmd_word_t w [`CMD_WORDS];
        int        stride, in_side, out_side, out_surf;
        int        cnt, s, pw, ph;
        logic      ok;
        op_count_t mac;
        dma_addr_t p2_exp;
        test_errs = 0;
        ok        = 1'b1;
        for (int i = 0; i < `CMD_WORDS; i++) w[i] = cmds[t][i*`CMD_WIDTH +: `CMD_WIDTH];
        stride   = w[0][11:8];
        in_side  = w[3][7:0];
        out_side = w[3][15:8];
        out_surf = w[3][31:16];
        cnt      = 0;
        while (!i_op_run && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!i_op_run) begin
            $display("%s: op_run never rose, the command was not started", names[t]);
            test_errs++;
        end else begin
            check_val(names[t], "op_type", w[0][2:0], i_op_type);
            check_val(names[t], "padding", w[0][4], i_padding);
            check_val(names[t], "stride", w[0][11:8], i_stride);
            check_val(names[t], "p3_start_addr", dma_addr_t'(w[4]), i_p3_start_addr);
            check_val(names[t], "result_addr", w[6], i_result_addr);
            check_val(names[t], "engine_reset", 1'b0, i_engine_reset); // Engine released
            check_val(names[t], "cmd_full", 1'b0, i_cmd_full); // Fewer words than the depth
            for (int k = 0; k < points[t] && ok; k++) begin
                s  = k % out_surf; // Channel groups repeat the same surface
                pw = s % out_side;
                ph = s / out_side;
                p2_exp = dma_addr_t'(w[5]) +
                         dma_addr_t'((ph * stride * in_side + pw * stride) * `PARA);
                if ((pw == 0 || pw == out_side - 1) && (ph == 0 || ph == out_side - 1))
                    mac = op_count_t'(w[1][15:0]);  // Corner
                else if (pw == 0 || pw == out_side - 1 || ph == 0 || ph == out_side - 1)
                    mac = op_count_t'(w[1][31:16]); // Edge
                else
                    mac = op_count_t'(w[0][31:16]); // Centre
                check_val(names[t], $sformatf("p2 point %0d", k), p2_exp, i_p2_start_addr);
                check_val(names[t], $sformatf("op_num point %0d", k), mac, i_op_num);
                cnt = 1;
                while (!i_point_done && i_op_run && cnt <= WAIT_LIMIT) begin
                    @(negedge clk);
                    cnt++;
                end
                if (i_point_done) begin
                    check_val(names[t], $sformatf("cycles point %0d", k), mac + 1, cnt);
                    @(negedge clk);
                end else if (i_op_run) begin
                    $display("%s: no point_done within %0d cycles", names[t], WAIT_LIMIT);
                    test_errs++;
                    ok = 1'b0;
                end else begin
                    check_val(names[t], "point count", points[t], k); // Run ended early
                    ok = 1'b0;
                end
            end
            if (ok) check_val(names[t], "op_run after last point", 1'b0, i_op_run);
        end
        close_test(names[t], points[t]);
    endtask

    task automatic check_completion();
        int cnt;
        test_errs = 0;
        cnt       = 0;
        while (!i_irq && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!i_irq) begin
            $display("completion: irq did not rise after the last command");
            test_errs++;
        end else begin
            check_val("completion", "dma_p1_reads_en", 1'b0, i_dma_p1_reads_en);
            repeat (HOLD_CHECK) begin // irq is sticky and the engine stays idle
                @(negedge clk);
                check_val("completion", "irq", 1'b1, i_irq);
                check_val("completion", "op_run", 1'b0, i_op_run);
            end
        end
        close_test("completion", 0);
    endtask

    initial begin
        int cnt;
        o_done   = 1'b0;
        o_errors = 0;
        n_pass   = 0;
        n_run    = 0;
        cnt      = 0;
        while (rst !== 1'b0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was never released");
            o_errors++;
        end
        for (int t = 0; t < names.size(); t++) run_test(t);
        check_completion();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_run, n_pass, n_run - n_pass, o_errors);
        o_done = 1'b1;
    end

endmodule

// ==== test/tb_cnn_ctrl.sv ====
`include "cnn_ctrl_defines.svh"

module tb_cnn_ctrl;
    import cnn_ctrl_pkg::*;

    localparam int    CLK_HALF   = 4;     // 8 unit clock period
    localparam int    DRIVE_DLY  = 1;     // Inputs change just after the rising edge
    localparam int    DONE_LIMIT = 20000; // Cycles allowed for the whole command list
    localparam string CMD_FILE   = "test/cmd_input.txt";

    logic        clk;
    logic        rst;
    logic        op_en;
    logic        cmd_wr_en;
    cmd_word_t   cmd_wr_data;
    logic [6:0]  cmd_size;
    logic        cmd_full;
    logic        dma_p1_reads_en;
    op_type_e    op_type;
    logic        padding;
    logic [3:0]  stride;
    op_count_t   op_num;
    dma_addr_t   p2_start_addr;
    dma_addr_t   p3_start_addr;
    mem_addr_t   result_addr;
    logic        op_run;
    logic        engine_reset;
    logic        point_done;
    logic        irq;
    logic        chk_done;
    int          chk_errors;
    cmd_word_t   cmd_words [$]; // Every command word in FIFO order
    int          n_tests;

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    cnn_ctrl_top dut_i (
        .clk (clk), .rst (rst), .i_op_en (op_en),
        .i_cmd_wr_en (cmd_wr_en), .i_cmd_wr_data (cmd_wr_data), .i_cmd_size (cmd_size),
        .o_cmd_full (cmd_full), .o_dma_p1_reads_en (dma_p1_reads_en),
        .o_op_type (op_type), .o_padding (padding), .o_stride (stride), .o_op_num (op_num),
        .o_p2_start_addr (p2_start_addr), .o_p3_start_addr (p3_start_addr),
        .o_result_addr (result_addr), .o_op_run (op_run), .o_engine_reset (engine_reset),
        .o_point_done (point_done), .o_irq (irq)
    );

    cnn_ctrl_checker chk_i (
        .clk (clk), .rst (rst), .i_op_type (op_type), .i_padding (padding),
        .i_stride (stride), .i_op_num (op_num), .i_p2_start_addr (p2_start_addr),
        .i_p3_start_addr (p3_start_addr), .i_result_addr (result_addr),
        .i_op_run (op_run), .i_point_done (point_done), .i_irq (irq),
        .i_dma_p1_reads_en (dma_p1_reads_en), .i_cmd_full (cmd_full),
        .i_engine_reset (engine_reset), .o_done (chk_done), .o_errors (chk_errors)
    );

    // Lines that do not scan as name, seven words and a count are skipped
    task automatic load_commands();
        int        fd;
        int        n;
        int        pts;
        string     line;
        string     name;
        cmd_word_t w [`CMD_WORDS];
        logic [`CMD_WORDS*`CMD_WIDTH-1:0] all_words;
        fd = $fopen(CMD_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s for reading", CMD_FILE);
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %d", name,
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], pts);
                if (n == 9) begin
                    for (int i = 0; i < `CMD_WORDS; i++) begin
                        cmd_words.push_back(w[i]);
                        all_words[i*`CMD_WIDTH +: `CMD_WIDTH] = w[i]; // Word 1 lowest
                    end
                    chk_i.add_test(name, all_words, pts);
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Called right after an edge plus the drive delay
    task automatic write_word(input cmd_word_t w);
        cmd_wr_en   = 1'b1;
        cmd_wr_data = w;
        @(posedge clk);
        #DRIVE_DLY;
        cmd_wr_en = 1'b0;
    endtask

    initial begin
        int unsigned seed;
        int          wait_cnt;
        rst         = 1'b1;
        op_en       = 1'b0;
        cmd_wr_en   = 1'b0;
        cmd_wr_data = '0;
        cmd_size    = '0;
        n_tests     = 0;
        seed        = 32'h2c6;
        seed        = $urandom(seed); // Seeds the idle gaps between writes
        load_commands();
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        if (n_tests > 0) begin
            foreach (cmd_words[i]) begin
                write_word(cmd_words[i]);
                repeat ($urandom % 3) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end
            cmd_size = 7'(n_tests);
            op_en    = 1'b1; // One cycle start pulse
            @(posedge clk);
            #DRIVE_DLY;
            op_en    = 1'b0;
            wait_cnt = 0;
            while (!chk_done && wait_cnt < DONE_LIMIT) begin
                @(posedge clk);
                wait_cnt++;
            end
        end else begin
            $display("No commands were loaded, nothing to run");
        end
        if (n_tests > 0 && chk_done && chk_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            if (n_tests > 0 && !chk_done)
                $display("Checker did not finish within %0d cycles", DONE_LIMIT);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/cnn_ctrl_pkg.sv
rtl/cnn_ctrl_ifs.sv
rtl/cmd_fifo.sv
rtl/cmd_sequencer.sv
rtl/op_timer.sv
rtl/cnn_ctrl_top.sv
test/cnn_ctrl_checker.sv
test/tb_cnn_ctrl.sv
